//--- bench/icache_checker.sv
`default_nettype none

module icache_checker (
  input wire                  clk,
  input wire                  rst,
  input wire                  fetch_rdata_valid_i,
  input wire                  mem_req_valid_i,
  input icache_pkg::mem_req_t mem_req_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // nothing pending in the first cycle out of reset
  a_quiet_after_reset: assert property (
    @(posedge clk) rst |=> !mem_req_valid_i && !fetch_rdata_valid_i
  ) else $error("memory request or fetch response active right after reset");

  // address and length held for the whole burst
  a_req_stable: assert property (
    @(posedge clk) disable iff (rst)
      mem_req_valid_i |=> !mem_req_valid_i || $stable(mem_req_i)
  ) else $error("memory request changed while valid");

  // response is a one-cycle pulse
  a_single_pulse: assert property (
    @(posedge clk) disable iff (rst) fetch_rdata_valid_i |=> !fetch_rdata_valid_i
  ) else $error("fetch response held high two cycles in a row");

endmodule

bind icache_top icache_checker u_checker (
  .clk                (clk),
  .rst                (rst),
  .fetch_rdata_valid_i(fetch_rdata_valid_o),
  .mem_req_valid_i    (mem_req_valid_o),
  .mem_req_i          (mem_req_o)
);

`default_nettype wire

//--- bench/tb_icache.sv
`default_nettype none

module tb_icache;
  timeunit 1ns;
  timeprecision 1ps;

  import icache_pkg::*;

  localparam addr_t UNC_BASE = 32'hA000_0000;

  // memory traffic seen during one fetch
  typedef enum logic [1:0] {TR_NONE, TR_BURST, TR_SINGLE, TR_OTHER} traffic_t;

  // one row of name, address, traffic and expected word
  typedef struct {
    string    name;
    addr_t    addr;
    traffic_t kind;
    word_t    word;
  } entry_t;

  logic     clk;
  logic     rst;
  logic     fetch_valid_i;
  addr_t    fetch_addr_i;
  word_t    fetch_rdata_o;
  logic     fetch_rdata_valid_o;
  mem_req_t mem_req_o;
  logic     mem_req_valid_o;
  logic     mem_rvalid_i;
  word_t    mem_rdata_i;

  entry_t   table_q[$];
  integer   seed;
  int       req_count;
  mem_req_t last_req;
  int       cycle_limit;
  int       word_errs;
  int       req_errs;
  int       traffic_errs;
  int       other_errs;

  icache_top #(.UNCACHED_BASE(UNC_BASE)) u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // memory word is the address with halves swapped and xored
  // uncached space answers one higher
  function automatic word_t bus_word(addr_t a);
    word_t w;
    w = {a[15:0], a[31:16]} ^ 32'h1357_9BDF;
    return (a >= UNC_BASE) ? w + 32'd1 : w;
  endfunction

  function automatic void add_entry(string name, addr_t addr, traffic_t kind);
    table_q.push_back('{name, addr, kind, bus_word(addr)});
  endfunction

  task automatic check_word(string name, word_t exp, word_t act);
    if (act !== exp) begin
      $display("FAILED %s: word expected %08h actual %08h", name, exp, act);
      word_errs++;
    end
  endtask

  task automatic check_req(string name, mem_req_t exp, mem_req_t act);
    if (act !== exp) begin
      $display("FAILED %s: request expected %08h len %0d actual %08h len %0d",
               name, exp.addr, exp.len, act.addr, act.len);
      req_errs++;
    end
  endtask

  task automatic check_traffic(string name, traffic_t exp, traffic_t act);
    if (act != exp) begin
      $display("FAILED %s: traffic expected %s actual %s", name, exp.name(), act.name());
      traffic_errs++;
    end
  endtask

  // memory model with 0 to 3 idle cycles before each beat
  initial begin : mem_model
    mem_req_t cur;
    int       gap;
    mem_rvalid_i = 1'b0;
    mem_rdata_i  = '0;
    forever begin
      @(posedge clk);
      #1;
      if (mem_req_valid_o) begin
        cur      = mem_req_o;
        last_req = cur;
        req_count++;
        for (int b = 0; b <= int'(cur.len); b++) begin
          gap = $unsigned($random(seed)) % 4;
          repeat (gap) begin
            @(posedge clk);
            #1;
          end
          // request stays up through every beat
          if (mem_req_valid_o !== 1'b1) begin
            $display("memory request dropped before beat %0d of %0d",
                     b, int'(cur.len) + 1);
            other_errs++;
          end
          mem_rvalid_i = 1'b1;
          mem_rdata_i  = bus_word(cur.addr + addr_t'(4 * b));
          @(posedge clk);
          #1;
          mem_rvalid_i = 1'b0;
        end
        // request gone in the cycle after the last beat
        if (mem_req_valid_o !== 1'b0) begin
          $display("memory request still valid in the cycle after its last beat");
          other_errs++;
        end
      end
    end
  end

  // run limit from table length plus reset
  initial begin : watchdog
    wait (cycle_limit > 0);
    repeat (cycle_limit) @(posedge clk);
    $display("timeout after %0d cycles, a fetch was never answered", cycle_limit);
    $display("Testbench failed");
    $finish;
  end

  // hold one fetch until the pulse and check word and traffic
  task automatic apply_entry(entry_t e);
    int       base;
    int       waited;
    traffic_t seen;
    mem_req_t exp_req;
    base          = req_count;
    waited        = 0;
    fetch_valid_i = 1'b1;
    fetch_addr_i  = e.addr;
    do begin
      @(posedge clk);
      #1;
      waited++;
    end while (!fetch_rdata_valid_o);
    check_word(e.name, e.word, fetch_rdata_o);
    case (req_count - base)
      0: seen = TR_NONE;
      1: seen = (last_req.len == 8'd0) ? TR_SINGLE : TR_BURST;
      default: seen = TR_OTHER;
    endcase
    check_traffic(e.name, e.kind, seen);
    // line aligned burst of 16 or exact address single beat
    exp_req.addr = (e.kind == TR_BURST) ? {e.addr[31:6], 6'b0} : e.addr;
    exp_req.len  = (e.kind == TR_BURST) ? 8'd15 : 8'd0;
    if (seen == e.kind && seen != TR_NONE) begin
      check_req(e.name, exp_req, last_req);
    end
    // hit answers the cycle after capture
    if (e.kind == TR_NONE && waited != 1) begin
      $display("FAILED %s: latency expected 1 actual %0d", e.name, waited);
      other_errs++;
    end
    @(posedge clk);
    #1;
    fetch_valid_i = 1'b0;
  endtask

  initial begin
    seed          = 64259;
    rst           = 1'b1;
    fetch_valid_i = 1'b0;
    fetch_addr_i  = '0;
    // cold line at index 65 and then hits across it
    add_entry("cold_miss", 32'h0000_1048, TR_BURST);
    add_entry("hit_same", 32'h0000_1048, TR_NONE);
    add_entry("hit_first_word", 32'h0000_1040, TR_NONE);
    add_entry("hit_last_word", 32'h0000_107C, TR_NONE);
    // bypass reads never allocate
    add_entry("uncached", 32'hA000_0104, TR_SINGLE);
    add_entry("uncached_again", 32'hA000_0104, TR_SINGLE);
    add_entry("uncached_top", 32'hFFFF_FFF0, TR_SINGLE);
    // tag 1 at the same index evicts tag 0
    add_entry("alias_miss", 32'h0000_3048, TR_BURST);
    add_entry("alias_hit", 32'h0000_3050, TR_NONE);
    add_entry("orig_miss_again", 32'h0000_1048, TR_BURST);
    add_entry("below_boundary", 32'h9FFF_FFC4, TR_BURST);
    // fill line 0 and read back every word
    add_entry("sweep_fill", 32'h0000_2024, TR_BURST);
    for (int i = 0; i < 16; i++) begin
      add_entry($sformatf("sweep_word%0d", i), 32'h0000_2000 + 4 * i, TR_NONE);
    end
    cycle_limit = table_q.size() * 100 + 10 + 4;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    // quiet outputs until the first fetch
    repeat (4) begin
      @(posedge clk);
      #1;
      if (mem_req_valid_o !== 1'b0 || fetch_rdata_valid_o !== 1'b0) begin
        $display("memory request or response active after reset with no fetch");
        other_errs++;
      end
    end
    foreach (table_q[i]) begin
      apply_entry(table_q[i]);
    end
    $display("errors: word %0d, request %0d, traffic %0d, other %0d",
             word_errs, req_errs, traffic_errs, other_errs);
    if (word_errs + req_errs + traffic_errs + other_errs == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
source/icache_pkg.sv
source/icache_req_stage.sv
source/icache_tag_array.sv
source/icache_data_array.sv
source/icache_ctrl.sv
source/icache_mem_port.sv
source/icache_top.sv
bench/icache_checker.sv
bench/tb_icache.sv

//--- source/icache_ctrl.sv
`default_nettype none

module icache_ctrl (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     fetch_valid_i,
  input  icache_pkg::req_fields_t req_i,
  input  wire                     hit_i,
  input  wire                     refill_done_i,
  input  wire                     uncached_done_i,
  output logic                    capture_o,
  output logic                    start_refill_o,
  output logic                    start_uncached_o,
  output logic                    rdata_valid_o
);

  import icache_pkg::*;

  ctrl_state_t state_q;
  ctrl_state_t state_d;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d          = state_q;
    capture_o        = 1'b0;
    start_refill_o   = 1'b0;
    start_uncached_o = 1'b0;
    rdata_valid_o    = 1'b0;
    case (state_q)
      IDLE: begin
        // take the held address, one fetch in flight at most
        if (fetch_valid_i) begin
          capture_o = 1'b1;
          state_d   = LOOKUP;
        end
      end
      LOOKUP: begin
        if (hit_i) begin
          // hit answers in this cycle
          rdata_valid_o = 1'b1;
          state_d       = IDLE;
        end else if (req_i.uncached) begin
          // single beat bypass read
          start_uncached_o = 1'b1;
          state_d          = UNCACHED;
        end else begin
          // cacheable miss, fetch whole line
          start_refill_o = 1'b1;
          state_d        = REFILL;
        end
      end
      REFILL: begin
        // back to idle, the held fetch is looked up again
        if (refill_done_i) begin
          state_d = IDLE;
        end
      end
      UNCACHED: begin
        // word lands in the mem port register at this edge
        if (uncached_done_i) begin
          state_d = UNC_RESP;
        end
      end
      UNC_RESP: begin
        rdata_valid_o = 1'b1;
        state_d       = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- source/icache_data_array.sv
`default_nettype none

module icache_data_array (
  input  wire                     clk,
  input  icache_pkg::req_fields_t req_i,
  input  wire                     beat_we_i,
  input  icache_pkg::beat_t       beat_sel_i,
  input  icache_pkg::word_t       beat_data_i,
  output icache_pkg::word_t       rdata_o
);

  import icache_pkg::*;

  // 128 lines of 16 words, 8 KB total
  word_t mem [NUM_LINES][LINE_WORDS];

  // refill writes one word per beat
  // beat number is the word position in the line
  always_ff @(posedge clk) begin
    if (beat_we_i) begin
      mem[req_i.index][beat_sel_i] <= beat_data_i;
    end
  end

  // async read at the registered request
  // valid only while the line is marked valid
  assign rdata_o = mem[req_i.index][req_i.word_sel];

endmodule

`default_nettype wire

//--- source/icache_mem_port.sv
`default_nettype none

module icache_mem_port (
  input  wire                     clk,
  input  wire                     rst,
  input  icache_pkg::req_fields_t req_i,
  input  wire                     start_refill_i,
  input  wire                     start_uncached_i,
  input  wire                     mem_rvalid_i,
  input  icache_pkg::word_t       mem_rdata_i,
  output icache_pkg::mem_req_t    mem_req_o,
  output logic                    mem_req_valid_o,
  output logic                    beat_we_o,
  output icache_pkg::beat_t       beat_sel_o,
  output icache_pkg::word_t       uncached_word_o,
  output logic                    refill_done_o,
  output logic                    uncached_done_o
);

  import icache_pkg::*;

  // last beat number of a line refill
  localparam beat_t LAST_BEAT = beat_t'(BURST_LEN);

  mem_req_t mem_req_q;
  logic     req_valid_q;
  logic     refill_q;
  beat_t    beat_q;
  word_t    unc_word_q;
  logic     beat;

  // a beat is any cycle with request and data valid together
  assign beat = req_valid_q && mem_rvalid_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      req_valid_q <= 1'b0;
      refill_q    <= 1'b0;
      beat_q      <= '0;
    end else if (start_refill_i || start_uncached_i) begin
      req_valid_q <= 1'b1;
      refill_q    <= start_refill_i;
      beat_q      <= '0;
    end else if (beat) begin
      if (!refill_q || beat_q == LAST_BEAT) begin
        // drops the cycle after the last beat
        req_valid_q <= 1'b0;
      end else begin
        beat_q <= beat_q + 1'b1;
      end
    end
  end

  // request stays put while valid
  always_ff @(posedge clk) begin
    if (start_refill_i) begin
      // line aligned, 16 beats
      mem_req_q.addr <= {req_i.tag, req_i.index, 6'b0};
      mem_req_q.len  <= BURST_LEN;
    end else if (start_uncached_i) begin
      // exact address, single beat
      mem_req_q.addr <= {req_i.tag, req_i.index, req_i.word_sel, req_i.byte_sel};
      mem_req_q.len  <= '0;
    end
  end

  // bypass word held for the response cycle
  always_ff @(posedge clk) begin
    if (beat && !refill_q) begin
      unc_word_q <= mem_rdata_i;
    end
  end

  assign mem_req_o       = mem_req_q;
  assign mem_req_valid_o = req_valid_q;
  assign uncached_word_o = unc_word_q;

  // refill write strobe, beat number picks the word
  assign beat_we_o       = beat && refill_q;
  assign beat_sel_o      = beat_q;
  assign refill_done_o   = beat_we_o && (beat_q == LAST_BEAT);
  assign uncached_done_o = beat && !refill_q;

endmodule

`default_nettype wire

//--- source/icache_pkg.sv
`default_nettype none

package icache_pkg;

  // cache geometry: 128 lines of 16 words, direct mapped
  localparam int LINE_WORDS = 16;
  localparam int NUM_LINES  = 128;

  // byte address and instruction word
  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;

  // address fields: tag 31:13, index 12:6, word 5:2
  typedef logic [18:0] tag_t;
  typedef logic [6:0]  index_t;
  typedef logic [3:0]  word_sel_t;

  // refill beat number and burst length code
  typedef logic [3:0] beat_t;
  typedef logic [7:0] burst_len_t;

  // length code 15 means 16 beats, one whole line
  localparam burst_len_t BURST_LEN = 8'd15;

  // registered fetch request, 33 bits
  typedef struct packed {
    tag_t       tag;
    index_t     index;
    word_sel_t  word_sel;
    logic [1:0] byte_sel;
    logic       uncached;
  } req_fields_t;

  // memory read request, 40 bits
  typedef struct packed {
    addr_t      addr;
    burst_len_t len;
  } mem_req_t;

  // controller states
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    REFILL,
    UNCACHED,
    UNC_RESP
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- source/icache_req_stage.sv
`default_nettype none

module icache_req_stage #(
  parameter icache_pkg::addr_t UNCACHED_BASE = 32'hA000_0000
) (
  input  wire                     clk,
  input  wire                     rst,
  input  icache_pkg::addr_t       fetch_addr_i,
  input  wire                     capture_i,
  output icache_pkg::req_fields_t req_o
);

  import icache_pkg::*;

  req_fields_t req_d;
  req_fields_t req_q;

  // split address into tag, index and offset
  always_comb begin
    {req_d.tag, req_d.index, req_d.word_sel, req_d.byte_sel} = fetch_addr_i;
    // everything from the boundary up bypasses the cache
    req_d.uncached = (fetch_addr_i >= UNCACHED_BASE);
  end

  // held until the controller takes the next fetch
  always_ff @(posedge clk) begin
    if (rst) begin
      req_q <= '0;
    end else if (capture_i) begin
      req_q <= req_d;
    end
  end

  assign req_o = req_q;

endmodule

`default_nettype wire

//--- source/icache_tag_array.sv
`default_nettype none

module icache_tag_array (
  input  wire                     clk,
  input  wire                     rst,
  input  icache_pkg::req_fields_t req_i,
  input  wire                     tag_we_i,
  output logic                    hit_o
);

  import icache_pkg::*;

  // one valid bit and one tag per line
  logic [NUM_LINES-1:0] valid_q;
  tag_t                 tag_mem [NUM_LINES];

  logic line_valid;
  tag_t line_tag;

  // valid bits start cleared, all lines empty
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (tag_we_i) begin
      valid_q[req_i.index] <= 1'b1;
    end
  end

  // tag of the refilled line
  always_ff @(posedge clk) begin
    if (tag_we_i) begin
      tag_mem[req_i.index] <= req_i.tag;
    end
  end

  // lookup of the indexed line
  assign line_valid = valid_q[req_i.index];
  assign line_tag   = tag_mem[req_i.index];

  // uncached space never hits, even on a matching tag
  assign hit_o = line_valid && (line_tag == req_i.tag) && !req_i.uncached;

endmodule

`default_nettype wire

//--- source/icache_top.sv
`default_nettype none

module icache_top #(
  parameter icache_pkg::addr_t UNCACHED_BASE = 32'hA000_0000
) (
  input  wire                  clk,
  input  wire                  rst,
  // fetch side
  input  wire                  fetch_valid_i,
  input  icache_pkg::addr_t    fetch_addr_i,
  output icache_pkg::word_t    fetch_rdata_o,
  output logic                 fetch_rdata_valid_o,
  // memory side
  output icache_pkg::mem_req_t mem_req_o,
  output logic                 mem_req_valid_o,
  input  wire                  mem_rvalid_i,
  input  icache_pkg::word_t    mem_rdata_i
);

  import icache_pkg::*;

  req_fields_t req;
  logic        capture;
  logic        hit;
  logic        start_refill;
  logic        start_uncached;
  logic        refill_done;
  logic        uncached_done;
  logic        beat_we;
  beat_t       beat_sel;
  word_t       cache_word;
  word_t       uncached_word;

  // input side: address register and tag lookup
  icache_req_stage #(
    .UNCACHED_BASE(UNCACHED_BASE)
  ) u_req_stage (
    .clk         (clk),
    .rst         (rst),
    .fetch_addr_i(fetch_addr_i),
    .capture_i   (capture),
    .req_o       (req)
  );

  // tag written on the last refill beat
  icache_tag_array u_tag_array (
    .clk     (clk),
    .rst     (rst),
    .req_i   (req),
    .tag_we_i(refill_done),
    .hit_o   (hit)
  );

  // refill words come straight from the memory bus
  icache_data_array u_data_array (
    .clk        (clk),
    .req_i      (req),
    .beat_we_i  (beat_we),
    .beat_sel_i (beat_sel),
    .beat_data_i(mem_rdata_i),
    .rdata_o    (cache_word)
  );

  icache_ctrl u_ctrl (
    .clk             (clk),
    .rst             (rst),
    .fetch_valid_i   (fetch_valid_i),
    .req_i           (req),
    .hit_i           (hit),
    .refill_done_i   (refill_done),
    .uncached_done_i (uncached_done),
    .capture_o       (capture),
    .start_refill_o  (start_refill),
    .start_uncached_o(start_uncached),
    .rdata_valid_o   (fetch_rdata_valid_o)
  );

  icache_mem_port u_mem_port (
    .clk             (clk),
    .rst             (rst),
    .req_i           (req),
    .start_refill_i  (start_refill),
    .start_uncached_i(start_uncached),
    .mem_rvalid_i    (mem_rvalid_i),
    .mem_rdata_i     (mem_rdata_i),
    .mem_req_o       (mem_req_o),
    .mem_req_valid_o (mem_req_valid_o),
    .beat_we_o       (beat_we),
    .beat_sel_o      (beat_sel),
    .uncached_word_o (uncached_word),
    .refill_done_o   (refill_done),
    .uncached_done_o (uncached_done)
  );

  // uncached requests answer from the captured bus word
  assign fetch_rdata_o = req.uncached ? uncached_word : cache_word;

endmodule

`default_nettype wire
